// File: src/memAccess_settings.svh
`ifndef MEM_ACCESS_SETTINGS_SVH
`define MEM_ACCESS_SETTINGS_SVH

// Width of one data word, a full RV64 doubleword.
`define XLEN 64

// Byte address width of the data memory, 4 KiB in total.
`define BYTE_ADDR_W 12

// Number of doublewords held by the RAM.
// Must equal 2**(BYTE_ADDR_W-3).
`define MEM_DEPTH 512

// Register address width on the APB side.
`define APB_ADDR_W 8

// Width of the event counters.
`define CNT_W 32

`endif

// File: src/memAccessPkg.sv
`include "memAccess_settings.svh"

package memAccessPkg;

  // One doubleword of load or store data.
  typedef logic [`XLEN-1:0] dword_t;

  typedef logic [`BYTE_ADDR_W-1:0] byteAddr_t;  // Byte address into the data memory.

  // Doubleword index, the byte address without its three lane bits.
  typedef logic [`BYTE_ADDR_W-4:0] wordIdx_t;

  typedef logic [7:0] byteMask_t;  // One enable per byte lane.

  // RISC-V funct3 for loads and stores. Bits 1:0 give the size, bit 2 marks unsigned.
  typedef logic [2:0] memOp_t;

  typedef logic [`CNT_W-1:0] count_t;

  typedef logic [`APB_ADDR_W-1:0] apbAddr_t;

  // Sequencer states. READ covers the cycle in which the RAM output is valid.
  typedef enum logic [1:0] {
    IDLE,
    READ,
    MERGE,
    RESP
  } seqState_t;

endpackage

// File: src/loadAligner.sv
`timescale 1ns/100ps

module loadAligner import memAccessPkg::*; (
  input  dword_t     rdata,
  input  memOp_t     op,
  input  logic [2:0] lane,
  output dword_t     loadData
);

  localparam int XlenBits = $bits(dword_t);

  logic [7:0]  byteLane;
  logic [15:0] halfLane;
  logic [31:0] wordLane;

  // The low lane bits drop out for wider accesses, so a misaligned address rounds down.
  always_comb begin
    byteLane = rdata[{lane, 3'b000} +: 8];
    halfLane = rdata[{lane[2:1], 4'b0000} +: 16];
    wordLane = rdata[{lane[2], 5'b00000} +: 32];
  end

  always_comb begin
    case (op[1:0])
      2'd0: begin
        if (op[2]) loadData = {{(XlenBits - 8){1'b0}}, byteLane};
        else loadData = {{(XlenBits - 8){byteLane[7]}}, byteLane};
      end
      2'd1: begin
        if (op[2]) loadData = {{(XlenBits - 16){1'b0}}, halfLane};
        else loadData = {{(XlenBits - 16){halfLane[15]}}, halfLane};
      end
      2'd2: begin
        if (op[2]) loadData = {{(XlenBits - 32){1'b0}}, wordLane};
        else loadData = {{(XlenBits - 32){wordLane[31]}}, wordLane};
      end
      default: loadData = rdata;  // ld takes the doubleword as it is.
    endcase
  end

endmodule

// File: src/storeMerger.sv
`timescale 1ns/100ps

module storeMerger import memAccessPkg::*; (
  input  dword_t     oldData,
  input  dword_t     wdata,
  input  memOp_t     op,
  input  logic [2:0] lane,
  output dword_t     mergedData
);

  byteMask_t  byteMask;
  logic [2:0] laneBase;
  dword_t     shifted;

  // Round the lane down to the access size and open the matching byte enables.
  always_comb begin
    case (op[1:0])
      2'd0: begin
        laneBase = lane;
        byteMask = 8'b0000_0001 << laneBase;
      end
      2'd1: begin
        laneBase = {lane[2:1], 1'b0};
        byteMask = 8'b0000_0011 << laneBase;
      end
      2'd2: begin
        laneBase = {lane[2], 2'b00};
        byteMask = 8'b0000_1111 << laneBase;
      end
      default: begin
        laneBase = 3'd0;
        byteMask = 8'hff;  // sd writes all eight bytes.
      end
    endcase
  end

  // The store value sits in the low bytes of wdata.
  assign shifted = wdata << {laneBase, 3'b000};

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      mergedData[i*8 +: 8] = byteMask[i] ? shifted[i*8 +: 8] : oldData[i*8 +: 8];
    end
  end

endmodule

// File: src/dataMemory.sv
`timescale 1ns/100ps
`include "memAccess_settings.svh"

module dataMemory import memAccessPkg::*; (
  input  logic     clk,
  input  wordIdx_t addr,
  input  logic     write,
  input  dword_t   wdata,
  output dword_t   rdata
);

  dword_t mem [`MEM_DEPTH];

  // The read port samples on every edge and returns the contents before any write
  // at the same edge. The sequencer depends on this for its read-modify-write.
  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

// File: src/accessSequencer.sv
`timescale 1ns/100ps

module accessSequencer import memAccessPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       reqValid,
  input  logic       reqWrite,
  input  memOp_t     reqOp,
  input  byteAddr_t  reqAddr,
  input  dword_t     reqWdata,
  input  logic       strictAlign,
  input  dword_t     alignedData,
  output logic       reqReady,
  output logic       rspValid,
  output dword_t     rspData,
  output logic       rspError,
  output wordIdx_t   memAddr,
  output logic       memWrite,
  output memOp_t     curOp,
  output logic [2:0] curLane,
  output dword_t     curWdata,
  output logic       loadDone,
  output logic       storeDone,
  output logic       faultEvent,
  output byteAddr_t  faultAddr
);

  seqState_t  state;
  seqState_t  stateNext;
  byteAddr_t  curAddr;
  logic       curWrite;
  logic       faultQ;
  logic       accept;
  logic       misaligned;
  logic [2:0] lowMask;

  assign accept = reqValid && reqReady;

  // Address bits that must be zero for the requested size.
  always_comb begin
    case (reqOp[1:0])
      2'd0: lowMask = 3'b000;
      2'd1: lowMask = 3'b001;
      2'd2: lowMask = 3'b011;
      default: lowMask = 3'b111;
    endcase
  end

  // Without strict mode a misaligned access simply rounds down in the data path.
  assign misaligned = strictAlign && ((reqAddr[2:0] & lowMask) != 3'b000);

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: if (accept) stateNext = misaligned ? RESP : READ;
      READ: stateNext = curWrite ? MERGE : RESP;
      MERGE: stateNext = RESP;
      RESP: stateNext = IDLE;
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= IDLE;
      reqReady <= 1'b0;  // Held low until the first edge after reset.
      curWrite <= 1'b0;
      faultQ <= 1'b0;
      rspData <= '0;
    end else begin
      state <= stateNext;
      reqReady <= (stateNext == IDLE);
      if (accept) begin
        curWrite <= reqWrite;
        faultQ <= misaligned;
        rspData <= '0;
      end else if (state == READ && !curWrite) begin
        rspData <= alignedData;  // RAM output is valid in READ.
      end
    end
  end

  // Request payload, captured once per accepted request.
  always_ff @(posedge clk) begin
    if (accept) begin
      curOp <= reqOp;
      curAddr <= reqAddr;
      curWdata <= reqWdata;
    end
  end

  // The RAM is addressed from the request itself in IDLE so that its data is ready in READ.
  assign memAddr = (state == IDLE) ? wordIdx_t'(reqAddr >> 3) : wordIdx_t'(curAddr >> 3);
  assign memWrite = (state == MERGE);
  assign curLane = curAddr[2:0];

  assign rspValid = (state == RESP);
  assign rspError = rspValid && faultQ;

  assign loadDone = rspValid && !curWrite && !faultQ;
  assign storeDone = rspValid && curWrite && !faultQ;
  assign faultEvent = rspValid && faultQ;
  assign faultAddr = curAddr;

  rspSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
    rspValid |=> !rspValid);

  // A write-back belongs to the non-faulting store accepted two edges earlier.
  writeAfterRead: assert property (@(posedge clk) disable iff (!rstN)
    memWrite |-> $past(accept && reqWrite && !misaligned, 2));

endmodule

// File: src/accessCsr.sv
`timescale 1ns/100ps

module accessCsr import memAccessPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apbAddr_t    paddr,
  input  logic [31:0] pwdata,
  input  logic        loadDone,
  input  logic        storeDone,
  input  logic        faultEvent,
  input  byteAddr_t   faultAddr,
  output logic [31:0] prdata,
  output logic        strictAlign
);

  localparam apbAddr_t AddrCtrl      = 'h00;
  localparam apbAddr_t AddrLoadCnt   = 'h04;
  localparam apbAddr_t AddrStoreCnt  = 'h08;
  localparam apbAddr_t AddrFaultCnt  = 'h0C;
  localparam apbAddr_t AddrFaultAddr = 'h10;

  count_t    loadCnt;
  count_t    storeCnt;
  count_t    faultCnt;
  byteAddr_t faultAddrQ;
  logic      ctrlWrite;
  logic      clearCnt;

  // Counters stop at all ones instead of wrapping.
  function automatic count_t satInc(count_t value);
    return (value == '1) ? value : value + 1'b1;
  endfunction

  assign ctrlWrite = psel && penable && pwrite && (paddr == AddrCtrl);
  assign clearCnt = ctrlWrite && pwdata[1];  // Self-clearing, never stored.

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      strictAlign <= 1'b0;
      loadCnt <= '0;
      storeCnt <= '0;
      faultCnt <= '0;
      faultAddrQ <= '0;
    end else begin
      if (ctrlWrite) strictAlign <= pwdata[0];

      // A clear wins over an event arriving in the same cycle.
      if (clearCnt) loadCnt <= '0;
      else if (loadDone) loadCnt <= satInc(loadCnt);

      if (clearCnt) storeCnt <= '0;
      else if (storeDone) storeCnt <= satInc(storeCnt);

      if (clearCnt) faultCnt <= '0;
      else if (faultEvent) faultCnt <= satInc(faultCnt);

      if (faultEvent) faultAddrQ <= faultAddr;
    end
  end

  always_comb begin
    case (paddr)
      AddrCtrl: prdata = {31'b0, strictAlign};
      AddrLoadCnt: prdata = 32'(loadCnt);
      AddrStoreCnt: prdata = 32'(storeCnt);
      AddrFaultCnt: prdata = 32'(faultCnt);
      AddrFaultAddr: prdata = 32'(faultAddrQ);
      default: prdata = 32'b0;
    endcase
  end

  apbEnableNeedsSel: assert property (@(posedge clk) disable iff (!rstN)
    penable |-> psel);

endmodule

// File: src/memAccessTop.sv
`timescale 1ns/100ps

module memAccessTop import memAccessPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        reqValid,
  input  logic        reqWrite,
  input  memOp_t      reqOp,
  input  byteAddr_t   reqAddr,
  input  dword_t      reqWdata,
  output logic        reqReady,
  output logic        rspValid,
  output dword_t      rspData,
  output logic        rspError,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apbAddr_t    paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata
);

  logic       strictAlign;
  dword_t     alignedData;
  wordIdx_t   memAddr;
  logic       memWrite;
  dword_t     memWdata;
  dword_t     memRdata;
  memOp_t     curOp;
  logic [2:0] curLane;
  dword_t     curWdata;
  logic       loadDone;
  logic       storeDone;
  logic       faultEvent;
  byteAddr_t  faultAddr;

  accessSequencer i_sequencer (
    .clk(clk), .rstN(rstN),
    .reqValid(reqValid), .reqWrite(reqWrite), .reqOp(reqOp), .reqAddr(reqAddr),
    .reqWdata(reqWdata), .strictAlign(strictAlign), .alignedData(alignedData),
    .reqReady(reqReady), .rspValid(rspValid), .rspData(rspData), .rspError(rspError),
    .memAddr(memAddr), .memWrite(memWrite), .curOp(curOp), .curLane(curLane),
    .curWdata(curWdata), .loadDone(loadDone), .storeDone(storeDone),
    .faultEvent(faultEvent), .faultAddr(faultAddr)
  );

  loadAligner i_loadAligner (
    .rdata(memRdata), .op(curOp), .lane(curLane), .loadData(alignedData)
  );

  // Old doubleword comes straight from the RAM read port.
  storeMerger i_storeMerger (
    .oldData(memRdata), .wdata(curWdata), .op(curOp), .lane(curLane),
    .mergedData(memWdata)
  );

  dataMemory i_dataMemory (
    .clk(clk), .addr(memAddr), .write(memWrite), .wdata(memWdata), .rdata(memRdata)
  );

  accessCsr i_csr (
    .clk(clk), .rstN(rstN),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .loadDone(loadDone), .storeDone(storeDone), .faultEvent(faultEvent),
    .faultAddr(faultAddr), .prdata(prdata), .strictAlign(strictAlign)
  );

endmodule

// File: verification/tbClockGen.sv
`timescale 1ns/100ps

module tbClockGen (
  output logic clk,
  output logic rstN
);

  localparam int ClkPeriod = 20;
  localparam int ResetCycles = 8;

  // Reset is released on a falling edge, clear of the rising edge that samples it.
  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    #(ResetCycles * ClkPeriod) rstN = 1'b1;
  end

  always #(ClkPeriod / 2) clk = ~clk;

endmodule

// File: verification/memAccessTb.sv
`timescale 1ns/100ps

module memAccessTb import memAccessPkg::*; ();

  localparam int ClkPeriod = 20;
  localparam int MemBytes = 1 << $bits(byteAddr_t);
  localparam int TotalRequests = 244;
  localparam int WatchdogCycles = TotalRequests * 10 + 1000;

  logic        clk;
  logic        rstN;
  logic        reqValid;
  logic        reqWrite;
  memOp_t      reqOp;
  byteAddr_t   reqAddr;
  dword_t      reqWdata;
  logic        reqReady;
  logic        rspValid;
  dword_t      rspData;
  logic        rspError;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apbAddr_t    paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;

  // Reference model state.
  logic [7:0] modelMem [0:MemBytes-1];
  logic       modelStrict;
  int         modelLoadCnt;
  int         modelStoreCnt;
  int         modelFaultCnt;
  byteAddr_t  modelLastFault;

  int          errorCount;
  int          checkCount;
  int          testErrorStart;
  int          seedValue;
  int          size;
  byteAddr_t   addrList [0:15];
  logic [31:0] regValue;

  tbClockGen i_clockGen (.clk(clk), .rstN(rstN));

  memAccessTop i_dut (
    .clk(clk), .rstN(rstN),
    .reqValid(reqValid), .reqWrite(reqWrite), .reqOp(reqOp), .reqAddr(reqAddr),
    .reqWdata(reqWdata), .reqReady(reqReady),
    .rspValid(rspValid), .rspData(rspData), .rspError(rspError),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata)
  );

  task automatic compareValues(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  function automatic int accessBytes(memOp_t op);
    return 1 << op[1:0];
  endfunction

  function automatic logic isFault(memOp_t op, byteAddr_t addr);
    return modelStrict && ((int'(addr) & (accessBytes(op) - 1)) != 0);
  endfunction

  // Little-endian lane read from the rounded-down address, then sign or zero extension.
  function automatic dword_t expectedLoad(memOp_t op, byteAddr_t addr);
    int     n;
    int     base;
    dword_t value;
    n = accessBytes(op);
    base = int'(addr) & ~(n - 1);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value[i*8 +: 8] = modelMem[base + i];
    end
    if (!op[2]) begin
      for (int j = n * 8; j < 64; j++) begin
        value[j] = value[n*8 - 1];
      end
    end
    return value;
  endfunction

  task automatic applyStore(input memOp_t op, input byteAddr_t addr, input dword_t wdata);
    int n;
    int base;
    n = accessBytes(op);
    base = int'(addr) & ~(n - 1);
    for (int i = 0; i < n; i++) begin
      modelMem[base + i] = wdata[i*8 +: 8];
    end
  endtask

  function automatic byteAddr_t randomAligned(int baseByte, int span, int sz);
    return byteAddr_t'((baseByte + $urandom % span) & ~((1 << sz) - 1));
  endfunction

  // Needs a size of at least a half so that a nonzero offset exists.
  function automatic byteAddr_t randomMisaligned(int sz);
    int n;
    int base;
    n = 1 << sz;
    base = (512 + $urandom % 256) & ~(n - 1);
    return byteAddr_t'(base + 1 + $urandom % (n - 1));
  endfunction

  task automatic writeRegister(input apbAddr_t addr, input logic [31:0] data);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic readRegister(input apbAddr_t addr, output logic [31:0] data);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    data = prdata;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // Starts and ends on a falling edge. With keepValid the request stays presented while busy.
  task automatic runRequest(input logic write, input memOp_t op, input byteAddr_t addr,
                            input dword_t wdata, input logic keepValid);
    logic   fault;
    dword_t expData;
    int     expEdges;
    int     edges;
    int     waitCnt;
    fault = isFault(op, addr);
    expData = (write || fault) ? '0 : expectedLoad(op, addr);
    expEdges = fault ? 1 : (write ? 3 : 2);
    reqValid = 1'b1;
    reqWrite = write;
    reqOp = op;
    reqAddr = addr;
    reqWdata = wdata;
    waitCnt = 0;
    while (!reqReady && waitCnt < 20) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!reqReady) begin
      errorCount++;
      $display("Error at %0t: reqReady never rose for the request at %h", $time, addr);
      reqValid = 1'b0;
      return;
    end
    @(negedge clk);  // Accepted on the edge just passed.
    if (!keepValid) reqValid = 1'b0;
    edges = 1;
    while (!rspValid && edges < 8) begin
      compareValues(reqReady, 1'b0, "reqReady while busy");
      @(negedge clk);
      edges++;
    end
    if (!rspValid) begin
      errorCount++;
      $display("Error at %0t: no response to the request at %h within %0d cycles",
               $time, addr, edges);
    end else begin
      if (edges > expEdges) begin
        errorCount++;
        $display("Error at %0t: response came late, %0d edges after acceptance instead of %0d",
                 $time, edges, expEdges);
      end else begin
        compareValues(edges, expEdges, "response latency");
      end
      compareValues(rspData, expData, "rspData");
      compareValues(rspError, fault, "rspError");
      compareValues(reqReady, 1'b0, "reqReady during response");
      @(negedge clk);
      compareValues(rspValid, 1'b0, "rspValid one cycle after response");
      compareValues(reqReady, 1'b1, "reqReady one cycle after response");
    end
    if (fault) begin
      modelFaultCnt++;
      modelLastFault = addr;
    end else if (write) begin
      applyStore(op, addr, wdata);
      modelStoreCnt++;
    end else begin
      modelLoadCnt++;
    end
  endtask

  task automatic reportTest(input int num, input string name);
    $display("Test %0d (%s) finished with %0d errors", num, name, errorCount - testErrorStart);
    testErrorStart = errorCount;
  endtask

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Run timed out after %0d cycles without finishing", WatchdogCycles);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqOp = '0;
    reqAddr = '0;
    reqWdata = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    modelStrict = 1'b0;
    modelLoadCnt = 0;
    modelStoreCnt = 0;
    modelFaultCnt = 0;
    modelLastFault = '0;
    errorCount = 0;
    checkCount = 0;
    testErrorStart = 0;
    seedValue = $urandom(71874);
    wait (rstN === 1'b1);
    @(negedge clk);

    // Doublewords 0 to 63 serve the first test only.
    for (int i = 0; i < 16; i++) begin
      addrList[i] = byteAddr_t'(($urandom % 64) * 8);
      runRequest(1'b1, 3'd3, addrList[i], {$urandom, $urandom}, 1'b0);
    end
    for (int i = 0; i < 16; i++) runRequest(1'b0, 3'd3, addrList[i], '0, 1'b0);
    reportTest(1, "aligned doubleword store and load");

    // Preset bytes 512 to 767, the region that all later tests use.
    for (int i = 0; i < 32; i++) runRequest(1'b1, 3'd3, 512 + i * 8, {$urandom, $urandom}, 1'b0);
    for (int i = 0; i < 40; i++) begin
      size = $urandom % 3;
      runRequest(1'b1, memOp_t'(size), randomAligned(512, 256, size), {$urandom, $urandom}, 1'b0);
    end
    for (int i = 0; i < 40; i++) begin
      size = $urandom % 4;
      runRequest(1'b0, {(size < 3) && ($urandom % 2 == 1), 2'(size)},
                 randomAligned(512, 256, size), '0, 1'b0);
    end
    reportTest(2, "sub-word store merge and load extension");

    for (int i = 0; i < 24; i++) begin
      size = 1 + $urandom % 3;
      runRequest($urandom % 2, {(size < 3) && ($urandom % 2 == 1), 2'(size)},
                 randomMisaligned(size), {$urandom, $urandom}, 1'b0);
    end
    reportTest(3, "misaligned accesses round down");

    writeRegister(8'h00, 32'h1);
    modelStrict = 1'b1;
    readRegister(8'h00, regValue);
    compareValues(regValue, 32'h1, "CTRL after strict enable");
    for (int i = 0; i < 16; i++) begin
      size = 1 + $urandom % 3;
      addrList[i] = randomMisaligned(size);
      runRequest($urandom % 2, memOp_t'(size), addrList[i], {$urandom, $urandom}, 1'b0);
    end
    // Faulting stores must not have touched these doublewords.
    for (int i = 0; i < 16; i++) runRequest(1'b0, 3'd3, addrList[i] & ~12'h7, '0, 1'b0);
    readRegister(8'h10, regValue);
    compareValues(regValue, modelLastFault, "FAULTADDR");
    reportTest(4, "strict mode faults");

    for (int i = 0; i < 40; i++) begin
      if (i == 20) begin
        writeRegister(8'h00, 32'h0);
        modelStrict = 1'b0;
      end
      size = $urandom % 4;
      runRequest($urandom % 2, {(size < 3) && ($urandom % 2 == 1), 2'(size)},
                 (size > 0 && $urandom % 3 == 0) ? randomMisaligned(size)
                                                 : randomAligned(512, 256, size),
                 {$urandom, $urandom}, 1'b0);
    end
    readRegister(8'h04, regValue);
    compareValues(regValue, modelLoadCnt, "LOADCNT");
    readRegister(8'h08, regValue);
    compareValues(regValue, modelStoreCnt, "STORECNT");
    readRegister(8'h0C, regValue);
    compareValues(regValue, modelFaultCnt, "FAULTCNT");
    writeRegister(8'h00, 32'h2);
    modelLoadCnt = 0;
    modelStoreCnt = 0;
    modelFaultCnt = 0;
    readRegister(8'h00, regValue);
    compareValues(regValue, 32'h0, "CTRL after counter clear");
    readRegister(8'h04, regValue);
    compareValues(regValue, 32'h0, "LOADCNT after clear");
    readRegister(8'h08, regValue);
    compareValues(regValue, 32'h0, "STORECNT after clear");
    readRegister(8'h0C, regValue);
    compareValues(regValue, 32'h0, "FAULTCNT after clear");
    reportTest(5, "event counters");

    // The held request is taken again as soon as reqReady returns.
    runRequest(1'b0, 3'd3, 12'd512, '0, 1'b1);
    runRequest(1'b0, 3'd3, 12'd512, '0, 1'b0);
    runRequest(1'b1, 3'd3, 12'd520, 64'h0123_4567_89ab_cdef, 1'b1);
    runRequest(1'b1, 3'd3, 12'd520, 64'h0123_4567_89ab_cdef, 1'b0);
    repeat (4) begin
      @(negedge clk);
      compareValues(rspValid, 1'b0, "rspValid while idle");
    end
    reportTest(6, "back-pressure on busy requests");

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/memAccessPkg.sv
src/loadAligner.sv
src/storeMerger.sv
src/dataMemory.sv
src/accessSequencer.sv
src/accessCsr.sv
src/memAccessTop.sv
verification/tbClockGen.sv
verification/memAccessTb.sv
